// File: Bender.yml
package:
  name: ising_core

sources:
  # Package first, then leaf blocks, then the top level
  - common/ising_pkg.sv
  - logic/ising_core_regs.sv
  - logic/coupling_mem.sv
  - energy/energy_ctrl.sv
  - energy/energy_accum.sv
  - logic/ising_core.sv

  # Testbench, top module tb_ising_core
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ising_core.sv

// File: all.f
common/ising_pkg.sv
logic/ising_core_regs.sv
logic/coupling_mem.sv
energy/energy_ctrl.sv
energy/energy_accum.sv
logic/ising_core.sv
testbench/tb_clk_gen.sv
testbench/tb_ising_core.sv

// File: common/ising_pkg.sv
// Ising core shared definitions
// Default sizes, register map and energy FSM states
`default_nettype none

package ising_pkg;

    ////////////////////
    // Default sizes
    ////////////////////
    localparam int unsigned NUM_SPIN_DEF   = 8;
    localparam int unsigned BIT_J_DEF      = 4;
    localparam int unsigned BIT_H_DEF      = 4;
    localparam int unsigned ENERGY_BIT_DEF = 16;

    // Host register port
    localparam int unsigned REG_DATA_BIT = 32;
    localparam int unsigned REG_ADDR_BIT = 3;

    ////////////////////
    // Register map
    ////////////////////
    // Word addresses 5 to 7 are unmapped
    typedef enum logic [REG_ADDR_BIT-1:0] {
        REG_CTRL   = 3'd0,
        REG_STATUS = 3'd1,
        REG_SPIN   = 3'd2,
        REG_HBIAS  = 3'd3,
        REG_ENERGY = 3'd4
    } reg_addr_e;

    ////////////////////
    // Energy FSM
    ////////////////////
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_DRAIN = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: energy/energy_accum.sv
// Energy accumulator
// Local field per row, times the row spin, summed over all rows
`timescale 1ns/1ps
`default_nettype none

module energy_accum import ising_pkg::*; #(
    parameter int unsigned NUM_SPIN   = NUM_SPIN_DEF,
    parameter int unsigned BIT_J      = BIT_J_DEF,
    parameter int unsigned BIT_H      = BIT_H_DEF,
    parameter int unsigned ENERGY_BIT = ENERGY_BIT_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         row_valid_i,
    input  logic [$clog2(NUM_SPIN)-1:0]  row_idx_i,
    input  logic                         row_last_i,
    input  logic [NUM_SPIN*BIT_J-1:0]    row_data_i,
    input  logic [NUM_SPIN-1:0]          spin_i,
    input  logic [NUM_SPIN*BIT_H-1:0]    hbias_i,
    output logic signed [ENERGY_BIT-1:0] energy_o,
    output logic                         energy_valid_o
);
    logic signed [BIT_J-1:0]      j_col [NUM_SPIN];
    logic signed [ENERGY_BIT-1:0] term  [NUM_SPIN];
    logic signed [BIT_H-1:0]      h_row;
    logic signed [ENERGY_BIT-1:0] field;
    logic signed [ENERGY_BIT-1:0] row_term;
    logic signed [ENERGY_BIT-1:0] acc_q;
    logic                         energy_valid_q;

    ////////////////////
    // Local field
    ////////////////////
    // Spin bit 1 adds J, spin bit 0 subtracts it
    for (genvar j = 0; j < NUM_SPIN; j++) begin : g_col
        assign j_col[j] = row_data_i[j*BIT_J +: BIT_J];
        assign term[j]  = spin_i[j] ? ENERGY_BIT'(j_col[j]) : -ENERGY_BIT'(j_col[j]);
    end

    assign h_row = hbias_i[row_idx_i*BIT_H +: BIT_H];

    always_comb begin
        field = h_row;
        for (int j = 0; j < NUM_SPIN; j++) begin
            field = field + term[j];
        end
    end

    assign row_term = spin_i[row_idx_i] ? field : -field;

    ////////////////////
    // Accumulate
    ////////////////////
    // Row 0 restarts the sum
    always_ff @(posedge clk_i) begin
        if (row_valid_i) begin
            acc_q <= (row_idx_i == '0) ? row_term : acc_q + row_term;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            energy_valid_q <= 1'b0;
        end else begin
            energy_valid_q <= row_valid_i && row_last_i;
        end
    end

    assign energy_o       = acc_q;
    assign energy_valid_o = energy_valid_q;

endmodule

`default_nettype wire

// File: energy/energy_ctrl.sv
// Energy engine control FSM
// Sequences the J row reads and tags each row in flight
`timescale 1ns/1ps
`default_nettype none

module energy_ctrl import ising_pkg::*; #(
    parameter int unsigned NUM_SPIN = NUM_SPIN_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        start_i,
    output logic                        cmpt_idle_o,
    output logic                        rd_en_o,
    output logic [$clog2(NUM_SPIN)-1:0] rd_addr_o,
    output logic                        row_valid_o,
    output logic [$clog2(NUM_SPIN)-1:0] row_idx_o,
    output logic                        row_last_o
);
    localparam int unsigned ADDR_W = $clog2(NUM_SPIN);

    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    logic [ADDR_W-1:0] cnt_q;
    logic              start_ok;
    logic              rd_en;
    logic              last_rd;
    logic              cmpt_idle_q;
    logic              row_valid_q;
    logic              row_last_q;
    logic [ADDR_W-1:0] row_idx_q;

    assign start_ok = start_i && (state_q == ST_IDLE);
    assign rd_en    = (state_q == ST_READ);
    assign last_rd  = rd_en && (cnt_q == ADDR_W'(NUM_SPIN - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (start_ok) state_d = ST_READ;
            ST_READ:  if (last_rd) state_d = ST_DRAIN;
            ST_DRAIN: state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            cmpt_idle_q <= 1'b1;
            row_valid_q <= 1'b0;
            row_last_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start_ok) begin
                cnt_q <= '0;
            end else if (rd_en) begin
                cnt_q <= cnt_q + 1'b1;
            end
            // Idle lags the FSM by one cycle so the last row has drained
            if (start_ok) begin
                cmpt_idle_q <= 1'b0;
            end else if (state_q == ST_IDLE) begin
                cmpt_idle_q <= 1'b1;
            end
            row_valid_q <= rd_en;
            row_last_q  <= last_rd;
        end
    end

    // Row index lines up with the memory data
    always_ff @(posedge clk_i) begin
        row_idx_q <= cnt_q;
    end

    assign cmpt_idle_o = cmpt_idle_q;
    assign rd_en_o     = rd_en;
    assign rd_addr_o   = cnt_q;
    assign row_valid_o = row_valid_q;
    assign row_idx_o   = row_idx_q;
    assign row_last_o  = row_last_q;

endmodule

`default_nettype wire

// File: logic/coupling_mem.sv
// Coupling matrix memory, one row of J per spin
// Host write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

module coupling_mem import ising_pkg::*; #(
    parameter int unsigned NUM_SPIN = NUM_SPIN_DEF,
    parameter int unsigned BIT_J    = BIT_J_DEF
) (
    input  logic                        clk_i,
    input  logic                        j_we_i,
    input  logic [$clog2(NUM_SPIN)-1:0] j_waddr_i,
    input  logic [NUM_SPIN*BIT_J-1:0]   j_wdata_i,
    input  logic                        rd_en_i,
    input  logic [$clog2(NUM_SPIN)-1:0] rd_addr_i,
    output logic [NUM_SPIN*BIT_J-1:0]   rd_data_o
);
    localparam int unsigned ROW_W = NUM_SPIN * BIT_J;

    logic [ROW_W-1:0] mem_q [NUM_SPIN];
    logic [ROW_W-1:0] rd_data_q;

    // Host row write
    always_ff @(posedge clk_i) begin
        if (j_we_i) begin
            mem_q[j_waddr_i] <= j_wdata_i;
        end
    end

    // One cycle read latency
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

// File: logic/ising_core.sv
// Ising core top level
// Register bank, coupling memory and energy engine
`timescale 1ns/1ps
`default_nettype none

module ising_core import ising_pkg::*; #(
    parameter int unsigned NUM_SPIN   = NUM_SPIN_DEF,
    parameter int unsigned BIT_J      = BIT_J_DEF,
    parameter int unsigned BIT_H      = BIT_H_DEF,
    parameter int unsigned ENERGY_BIT = ENERGY_BIT_DEF
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        reg_valid_i,
    input  logic                        reg_write_i,
    input  logic [REG_ADDR_BIT-1:0]     reg_addr_i,
    input  logic [REG_DATA_BIT-1:0]     reg_wdata_i,
    input  logic                        j_we_i,
    input  logic [$clog2(NUM_SPIN)-1:0] j_waddr_i,
    input  logic [NUM_SPIN*BIT_J-1:0]   j_wdata_i,
    output logic [REG_DATA_BIT-1:0]     reg_rdata_o,
    output logic                        reg_rvalid_o,
    output logic                        reg_error_o
);
    localparam int unsigned ROW_W  = NUM_SPIN * BIT_J;
    localparam int unsigned ADDR_W = $clog2(NUM_SPIN);

    logic                         start;
    logic                         cmpt_idle;
    logic [NUM_SPIN-1:0]          spin;
    logic [NUM_SPIN*BIT_H-1:0]    hbias;
    logic signed [ENERGY_BIT-1:0] energy;
    logic                         energy_valid;
    logic                         rd_en;
    logic [ADDR_W-1:0]            rd_addr;
    logic [ROW_W-1:0]             rd_data;
    logic                         row_valid;
    logic [ADDR_W-1:0]            row_idx;
    logic                         row_last;

    ////////////////////
    // Register bank
    ////////////////////
    ising_core_regs #(
        .NUM_SPIN       (NUM_SPIN      ),
        .BIT_H          (BIT_H         ),
        .ENERGY_BIT     (ENERGY_BIT    )
    ) u_ising_core_regs (
        .clk_i          (clk_i         ),
        .rst_n_i        (rst_n_i       ),
        .reg_valid_i    (reg_valid_i   ),
        .reg_write_i    (reg_write_i   ),
        .reg_addr_i     (reg_addr_i    ),
        .reg_wdata_i    (reg_wdata_i   ),
        .reg_rdata_o    (reg_rdata_o   ),
        .reg_rvalid_o   (reg_rvalid_o  ),
        .reg_error_o    (reg_error_o   ),
        .cmpt_idle_i    (cmpt_idle     ),
        .energy_i       (energy        ),
        .energy_valid_i (energy_valid  ),
        .start_o        (start         ),
        .spin_o         (spin          ),
        .hbias_o        (hbias         )
    );

    ////////////////////
    // J memory
    ////////////////////
    coupling_mem #(
        .NUM_SPIN  (NUM_SPIN ),
        .BIT_J     (BIT_J    )
    ) u_coupling_mem (
        .clk_i     (clk_i    ),
        .j_we_i    (j_we_i   ),
        .j_waddr_i (j_waddr_i),
        .j_wdata_i (j_wdata_i),
        .rd_en_i   (rd_en    ),
        .rd_addr_i (rd_addr  ),
        .rd_data_o (rd_data  )
    );

    ////////////////////
    // Energy engine
    ////////////////////
    energy_ctrl #(
        .NUM_SPIN    (NUM_SPIN )
    ) u_energy_ctrl (
        .clk_i       (clk_i    ),
        .rst_n_i     (rst_n_i  ),
        .start_i     (start    ),
        .cmpt_idle_o (cmpt_idle),
        .rd_en_o     (rd_en    ),
        .rd_addr_o   (rd_addr  ),
        .row_valid_o (row_valid),
        .row_idx_o   (row_idx  ),
        .row_last_o  (row_last )
    );

    energy_accum #(
        .NUM_SPIN       (NUM_SPIN    ),
        .BIT_J          (BIT_J       ),
        .BIT_H          (BIT_H       ),
        .ENERGY_BIT     (ENERGY_BIT  )
    ) u_energy_accum (
        .clk_i          (clk_i       ),
        .rst_n_i        (rst_n_i     ),
        .row_valid_i    (row_valid   ),
        .row_idx_i      (row_idx     ),
        .row_last_i     (row_last    ),
        .row_data_i     (rd_data     ),
        .spin_i         (spin        ),
        .hbias_i        (hbias       ),
        .energy_o       (energy      ),
        .energy_valid_o (energy_valid)
    );

endmodule

`default_nettype wire

// File: logic/ising_core_regs.sv
// Ising core register bank
// Host decode, operand registers, start pulse and energy latch
`timescale 1ns/1ps
`default_nettype none

module ising_core_regs import ising_pkg::*; #(
    parameter int unsigned NUM_SPIN   = NUM_SPIN_DEF,
    parameter int unsigned BIT_H      = BIT_H_DEF,
    parameter int unsigned ENERGY_BIT = ENERGY_BIT_DEF
) (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         reg_valid_i,
    input  logic                         reg_write_i,
    input  logic [REG_ADDR_BIT-1:0]      reg_addr_i,
    input  logic [REG_DATA_BIT-1:0]      reg_wdata_i,
    output logic [REG_DATA_BIT-1:0]      reg_rdata_o,
    output logic                         reg_rvalid_o,
    output logic                         reg_error_o,
    input  logic                         cmpt_idle_i,
    input  logic signed [ENERGY_BIT-1:0] energy_i,
    input  logic                         energy_valid_i,
    output logic                         start_o,
    output logic [NUM_SPIN-1:0]          spin_o,
    output logic [NUM_SPIN*BIT_H-1:0]    hbias_o
);
    localparam int unsigned HB_W = NUM_SPIN * BIT_H;

    reg_addr_e                    addr;
    logic                         wr_acc;
    logic                         rd_acc;
    logic                         bad_addr;
    logic                         ro_hit;
    logic                         err_d;
    logic [REG_DATA_BIT-1:0]      rdata_d;
    logic [NUM_SPIN-1:0]          spin_q;
    logic [HB_W-1:0]              hbias_q;
    logic signed [ENERGY_BIT-1:0] energy_q;
    logic                         energy_done_q;
    logic [REG_DATA_BIT-1:0]      rdata_q;
    logic                         rvalid_q;
    logic                         error_q;

    assign addr   = reg_addr_e'(reg_addr_i);
    assign wr_acc = reg_valid_i && reg_write_i;
    assign rd_acc = reg_valid_i && !reg_write_i;

    ////////////////////
    // Decode
    ////////////////////
    always_comb begin
        bad_addr = 1'b0;
        ro_hit   = 1'b0;
        rdata_d  = '0;
        case (addr)
            // Start is a pulse only, reads as zero
            REG_CTRL:   rdata_d = '0;
            REG_STATUS: begin
                ro_hit       = 1'b1;
                rdata_d[1:0] = {energy_done_q, cmpt_idle_i};
            end
            REG_SPIN:   rdata_d[NUM_SPIN-1:0] = spin_q;
            REG_HBIAS:  rdata_d[HB_W-1:0] = hbias_q;
            REG_ENERGY: begin
                ro_hit  = 1'b1;
                rdata_d = {{(REG_DATA_BIT-ENERGY_BIT){energy_q[ENERGY_BIT-1]}}, energy_q};
            end
            default:    bad_addr = 1'b1;
        endcase
    end

    assign err_d = reg_valid_i && (bad_addr || (reg_write_i && ro_hit));

    // Start dropped while a run is in progress
    assign start_o = wr_acc && (addr == REG_CTRL) && reg_wdata_i[0] && cmpt_idle_i;

    ////////////////////
    // Operands
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            spin_q  <= '0;
            hbias_q <= '0;
        end else if (wr_acc && cmpt_idle_i) begin
            if (addr == REG_SPIN) begin
                spin_q <= reg_wdata_i[NUM_SPIN-1:0];
            end
            if (addr == REG_HBIAS) begin
                hbias_q <= reg_wdata_i[HB_W-1:0];
            end
        end
    end

    // Energy result and sticky done
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            energy_q      <= '0;
            energy_done_q <= 1'b0;
        end else begin
            if (energy_valid_i) begin
                energy_q <= energy_i;
            end
            if (start_o) begin
                energy_done_q <= 1'b0;
            end else if (energy_valid_i) begin
                energy_done_q <= 1'b1;
            end
        end
    end

    ////////////////////
    // Response
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
            error_q  <= 1'b0;
        end else begin
            rvalid_q <= rd_acc && !bad_addr;
            error_q  <= err_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            rdata_q <= rdata_d;
        end
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;
    assign reg_error_o  = error_q;
    assign spin_o       = spin_q;
    assign hbias_o      = hbias_q;

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset source
// Free running clock, active low reset held for a fixed cycle count
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real         PERIOD_NS  = 20.0,
    parameter int unsigned RST_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset released 1 ns after an edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/tb_ising_core.sv
// Ising core testbench
// Register, directed and random energy runs checked against a behavioral model
`timescale 1ns/1ps
`default_nettype none

module tb_ising_core import ising_pkg::*; ();
    localparam int unsigned NUM_SPIN    = NUM_SPIN_DEF;
    localparam int unsigned BIT_J       = BIT_J_DEF;
    localparam int unsigned BIT_H       = BIT_H_DEF;
    localparam int unsigned ROW_W       = NUM_SPIN * BIT_J;
    localparam int unsigned HB_W        = NUM_SPIN * BIT_H;
    localparam int unsigned ADDR_W      = $clog2(NUM_SPIN);
    localparam int unsigned NUM_TESTS   = 5;
    localparam int unsigned NUM_TRIALS  = 20;
    localparam int unsigned POLL_LIMIT  = 50;
    localparam int unsigned WDOG_CYCLES = NUM_TESTS * 200 + 500;

    logic                    clk;
    logic                    rst_n;
    logic                    reg_valid;
    logic                    reg_write;
    logic [REG_ADDR_BIT-1:0] reg_addr;
    logic [REG_DATA_BIT-1:0] reg_wdata;
    logic                    j_we;
    logic [ADDR_W-1:0]       j_waddr;
    logic [ROW_W-1:0]        j_wdata;
    logic [REG_DATA_BIT-1:0] reg_rdata;
    logic                    reg_rvalid;
    logic                    reg_error;

    // Model copy of the J rows held in the DUT
    logic [ROW_W-1:0] j_model [NUM_SPIN];
    integer           seed;
    int               test_errors;
    int               pass_tests;
    int               fail_tests;

    tb_clk_gen #(
        .PERIOD_NS  (20.0 ),
        .RST_CYCLES (10   )
    ) u_tb_clk_gen (
        .clk_o      (clk  ),
        .rst_n_o    (rst_n)
    );

    ising_core #(
        .NUM_SPIN     (NUM_SPIN      ),
        .BIT_J        (BIT_J         ),
        .BIT_H        (BIT_H         ),
        .ENERGY_BIT   (ENERGY_BIT_DEF)
    ) u_ising_core (
        .clk_i        (clk           ),
        .rst_n_i      (rst_n         ),
        .reg_valid_i  (reg_valid     ),
        .reg_write_i  (reg_write     ),
        .reg_addr_i   (reg_addr      ),
        .reg_wdata_i  (reg_wdata     ),
        .j_we_i       (j_we          ),
        .j_waddr_i    (j_waddr       ),
        .j_wdata_i    (j_wdata       ),
        .reg_rdata_o  (reg_rdata     ),
        .reg_rvalid_o (reg_rvalid    ),
        .reg_error_o  (reg_error     )
    );

    initial begin
        repeat (WDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            pass_tests++;
            $display("[%0t] %s: passed", $time, name);
        end else begin
            fail_tests++;
            $display("[%0t] %s: failed with %0d errors", $time, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [31:0] data, input logic exp_err);
        @(posedge clk);
        #1;
        reg_valid = 1'b1;
        reg_write = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk);
        #1;
        reg_valid = 1'b0;
        reg_write = 1'b0;
        check_value(reg_error, exp_err, $sformatf("error flag on write to %0d", addr));
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [31:0] data, input logic exp_err);
        @(posedge clk);
        #1;
        reg_valid = 1'b1;
        reg_write = 1'b0;
        reg_addr  = addr;
        @(posedge clk);
        #1;
        reg_valid = 1'b0;
        data      = reg_rdata;
        check_value(reg_error, exp_err, $sformatf("error flag on read of %0d", addr));
        check_value(reg_rvalid, !exp_err, $sformatf("rvalid on read of %0d", addr));
    endtask

    task automatic write_j_row(input int row, input logic [ROW_W-1:0] data);
        @(posedge clk);
        #1;
        j_we    = 1'b1;
        j_waddr = row[ADDR_W-1:0];
        j_wdata = data;
        @(posedge clk);
        #1;
        j_we         = 1'b0;
        j_model[row] = data;
    endtask

    // Poll status until energy_done or until POLL_LIMIT reads
    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[1] && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, status, 1'b0);
            polls++;
        end
        if (!status[1]) begin
            $display("Timeout: energy_done still clear after %0d status reads", POLL_LIMIT);
            test_errors++;
        end
    endtask

    task automatic run_energy(input logic [NUM_SPIN-1:0] spin, input logic [HB_W-1:0] hbias,
                              output logic [31:0] energy);
        logic [31:0] status;
        write_reg(REG_SPIN, spin, 1'b0);
        write_reg(REG_HBIAS, hbias, 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        wait_done(status);
        check_value(status, 32'h3, "status after run");
        read_reg(REG_ENERGY, energy, 1'b0);
    endtask

    function automatic logic [ROW_W-1:0] fill_row(input int val);
        logic [ROW_W-1:0] row;
        for (int j = 0; j < NUM_SPIN; j++) begin
            row[j*BIT_J +: BIT_J] = val;
        end
        return row;
    endfunction

    function automatic logic [ROW_W-1:0] random_row();
        logic [ROW_W-1:0] row;
        for (int j = 0; j < NUM_SPIN; j++) begin
            row[j*BIT_J +: BIT_J] = $random(seed);
        end
        return row;
    endfunction

    function automatic logic [HB_W-1:0] random_hbias();
        logic [HB_W-1:0] hb;
        for (int i = 0; i < NUM_SPIN; i++) begin
            hb[i*BIT_H +: BIT_H] = $random(seed);
        end
        return hb;
    endfunction

    // Sum over rows of s_i * (sum_j J_ij * s_j + h_i) with the diagonal included
    function automatic int model_energy(input logic [NUM_SPIN-1:0] spin,
                                        input logic [HB_W-1:0] hbias);
        int total;
        int field;
        int jv;
        total = 0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            field = $signed(hbias[i*BIT_H +: BIT_H]);
            for (int j = 0; j < NUM_SPIN; j++) begin
                jv    = $signed(j_model[i][j*BIT_J +: BIT_J]);
                field = spin[j] ? field + jv : field - jv;
            end
            total = spin[i] ? total + field : total - field;
        end
        return total;
    endfunction

    ////////////////////
    // Tests
    ////////////////////
    initial begin
        logic [31:0]         rdata;
        logic [31:0]         status;
        logic [31:0]         energy_first;
        logic [NUM_SPIN-1:0] spin_a;
        logic [HB_W-1:0]     hb;
        seed        = 83289;
        reg_valid   = 1'b0;
        reg_write   = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        j_we        = 1'b0;
        j_waddr     = '0;
        j_wdata     = '0;
        test_errors = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        wait (rst_n === 1'b1);

        read_reg(REG_STATUS, rdata, 1'b0);
        check_value(rdata, 32'h1, "status after reset");
        read_reg(REG_ENERGY, rdata, 1'b0);
        check_value(rdata, 32'h0, "energy after reset");
        read_reg(REG_CTRL, rdata, 1'b0);
        check_value(rdata, 32'h0, "ctrl after reset");
        end_test("reset state");

        spin_a = $random(seed);
        hb     = random_hbias();
        write_reg(REG_SPIN, spin_a, 1'b0);
        read_reg(REG_SPIN, rdata, 1'b0);
        check_value(rdata, spin_a, "spin readback");
        write_reg(REG_HBIAS, hb, 1'b0);
        read_reg(REG_HBIAS, rdata, 1'b0);
        check_value(rdata, hb, "hbias readback");
        read_reg(3'd6, rdata, 1'b1);
        write_reg(REG_ENERGY, 32'h1234, 1'b1);
        read_reg(REG_ENERGY, rdata, 1'b0);
        check_value(rdata, 32'h0, "energy after read-only write");
        end_test("register access");

        // All up with unit couplings gives NUM_SPIN squared
        for (int r = 0; r < NUM_SPIN; r++) begin
            write_j_row(r, fill_row(1));
        end
        spin_a = '1;
        run_energy(spin_a, '0, rdata);
        check_value(rdata, NUM_SPIN * NUM_SPIN, "all up energy");
        spin_a[0] = 1'b0;
        run_energy(spin_a, '0, rdata);
        check_value(rdata, model_energy(spin_a, '0), "spin 0 flipped energy");
        end_test("directed energy");

        for (int t = 0; t < NUM_TRIALS; t++) begin
            for (int r = 0; r < NUM_SPIN; r++) begin
                write_j_row(r, random_row());
            end
            spin_a = $random(seed);
            hb     = random_hbias();
            run_energy(spin_a, hb, rdata);
            check_value(rdata, model_energy(spin_a, hb), $sformatf("random trial %0d", t));
        end
        end_test("random energy");

        // Operand write and second start both land while busy
        spin_a = $random(seed);
        hb     = random_hbias();
        write_reg(REG_SPIN, spin_a, 1'b0);
        write_reg(REG_HBIAS, hb, 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        write_reg(REG_SPIN, ~spin_a, 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        wait_done(status);
        read_reg(REG_ENERGY, energy_first, 1'b0);
        check_value(energy_first, model_energy(spin_a, hb), "busy run energy");
        read_reg(REG_SPIN, rdata, 1'b0);
        check_value(rdata, spin_a, "spin kept during run");
        repeat (2 * NUM_SPIN + 8) @(posedge clk);
        read_reg(REG_STATUS, rdata, 1'b0);
        check_value(rdata, 32'h3, "status after second poll");
        read_reg(REG_ENERGY, rdata, 1'b0);
        check_value(rdata, model_energy(spin_a, hb), "energy after second poll");
        end_test("busy protection");

        $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
